//--- soc_pkg.sv
`default_nettype none

package soc_pkg;

	// Bus geometry
	localparam int ARCH_BITS = 32;
	localparam int ADDR_BITS = ARCH_BITS - 2;
	localparam int SEL_BITS = ARCH_BITS / 8;
	localparam int SLOT_WORDS = 16;
	localparam int SLOT_OFS_BITS = 4;

	typedef enum logic [1:0] {
		OP_NOP = 2'd0,
		OP_WR = 2'd1,
		OP_RD = 2'd2,
		// Returns the old word and writes the new one
		OP_RDWR = 2'd3
	} pi1_op_e;

	// Address map, one slot per slave
	localparam int S_DEVTBL = 0;
	localparam int S_GP0IO = 1;
	localparam int S_GP1IO = 2;
	localparam int S_INTCTRL = 3;
	localparam int S_INVALIDDEV = 4;
	localparam int SLAVE_COUNT = 5;
	localparam int SLV_IDX_BITS = 3;

	// Device table contents
	localparam logic [ARCH_BITS-1:0] SOC_ID = 2;
	localparam logic [ARCH_BITS-2:0] DEVTBL_IDS [SLAVE_COUNT] = '{7, 6, 6, 3, 0};
	localparam logic [SLAVE_COUNT-1:0] DEVTBL_USEINTR = 5'b00110;
	localparam logic [ARCH_BITS-1:0] SLOT_MAPSZ_BYTES = 64;
	localparam logic [ARCH_BITS-1:0] INVALID_MAPSZ_BYTES = 4096;
	localparam logic [SLOT_OFS_BITS-1:0] DEVTBL_RST_OFS = 4'd15;

	// GPIO banks and interrupt sources
	localparam int GP0_COUNT = 16;
	localparam int GP1_COUNT = 5;
	localparam int INT_SRC_COUNT = 2;
	localparam int INT_SRC_GP0 = 0;
	localparam int INT_SRC_GP1 = 1;
	localparam int INT_IDX_BITS = 4;

	// Reset sequencing
	localparam int RST_CYCLES = 32;
	localparam int RST_CNT_BITS = 6;

	typedef enum logic [1:0] {
		RST_NONE = 2'd0,
		RST_WARM = 2'd1,
		RST_COLD = 2'd2,
		RST_PWROFF = 2'd3
	} rst_req_e;

	function automatic logic op_reads(input pi1_op_e op);
		return (op == OP_RD) || (op == OP_RDWR);
	endfunction

	function automatic logic op_writes(input pi1_op_e op);
		return (op == OP_WR) || (op == OP_RDWR);
	endfunction

	// Replace only the bytes whose select bit is set
	function automatic logic [ARCH_BITS-1:0] byte_merge(
		input logic [ARCH_BITS-1:0] old_word,
		input logic [ARCH_BITS-1:0] new_word,
		input logic [SEL_BITS-1:0] sel
	);
		logic [ARCH_BITS-1:0] merged;
		merged = old_word;
		for (int b = 0; b < SEL_BITS; b++) begin
			if (sel[b]) begin
				merged[b*8 +: 8] = new_word[b*8 +: 8];
			end
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

//--- reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer import soc_pkg::*; (
	input logic clk_2x_w,
	input logic rst_p,
	input rst_req_e rst_req_i,
	output logic sys_rst_o
);

	logic [RST_CNT_BITS-1:0] rst_cnt;
	logic pwroff_q;
	logic reload;

	// Cold reset behaves like a warm one here
	assign reload = rst_p || (rst_req_i == RST_WARM) || (rst_req_i == RST_COLD);

	always_ff @(posedge clk_2x_w) begin
		if (reload) begin
			rst_cnt <= RST_CNT_BITS'(RST_CYCLES);
		end else if (rst_cnt != '0) begin
			rst_cnt <= rst_cnt - 1'b1;
		end
	end

	// Power-off holds the system until the external reset is pulsed
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (rst_req_i == RST_PWROFF) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (rst_cnt != '0) || pwroff_q;

endmodule

`default_nettype wire

//--- pi1_bus_decode.sv
`timescale 1ns/1ps
`default_nettype none

module pi1_bus_decode import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input pi1_op_e m_op_i,
	input logic [ADDR_BITS-1:0] m_addr_i,
	input logic [ARCH_BITS-1:0] m_data_i,
	input logic [SEL_BITS-1:0] m_sel_i,
	output logic [ARCH_BITS-1:0] m_data_o,
	output logic m_rdy_o,
	output pi1_op_e s_op_o [SLAVE_COUNT],
	output logic [SLOT_OFS_BITS-1:0] s_ofs_o,
	output logic [ARCH_BITS-1:0] s_data_o,
	output logic [SEL_BITS-1:0] s_sel_o,
	input logic [ARCH_BITS-1:0] s_data_i [SLAVE_COUNT]
);

	logic [ADDR_BITS-SLOT_OFS_BITS-1:0] slot;
	logic [SLV_IDX_BITS-1:0] sel_idx;
	logic [SLV_IDX_BITS-1:0] rd_idx;
	logic rd_vld;
	logic accept;

	// Word address divided by the slot size
	assign slot = m_addr_i[ADDR_BITS-1:SLOT_OFS_BITS];

	// Everything past the last real slot falls on the invalid device
	assign sel_idx = (slot < S_INVALIDDEV) ? slot[SLV_IDX_BITS-1:0] :
		SLV_IDX_BITS'(S_INVALIDDEV);

	// All slaves answer in one cycle, so reset is the only stall
	assign m_rdy_o = !sys_rst_i;
	assign accept = (m_op_i != OP_NOP) && m_rdy_o;

	assign s_ofs_o = m_addr_i[SLOT_OFS_BITS-1:0];
	assign s_data_o = m_data_i;
	assign s_sel_o = m_sel_i;

	always_comb begin
		for (int i = 0; i < SLAVE_COUNT; i++) begin
			s_op_o[i] = (accept && (sel_idx == i)) ? m_op_i : OP_NOP;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			rd_vld <= 1'b0;
		end else begin
			rd_vld <= accept && op_reads(m_op_i);
		end
	end

	// Remember who answers the read on the next cycle
	always_ff @(posedge clk_2x_w) begin
		if (accept) begin
			rd_idx <= sel_idx;
		end
	end

	// Invalid device reads zero
	always_comb begin
		m_data_o = '0;
		if (rd_vld && (rd_idx != SLV_IDX_BITS'(S_INVALIDDEV))) begin
			m_data_o = s_data_i[rd_idx];
		end
	end

endmodule

`default_nettype wire

//--- dev_table.sv
`timescale 1ns/1ps
`default_nettype none

module dev_table import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input pi1_op_e op_i,
	input logic [SLOT_OFS_BITS-1:0] ofs_i,
	input logic [ARCH_BITS-1:0] data_i,
	input logic [SEL_BITS-1:0] sel_i,
	output logic [ARCH_BITS-1:0] data_o,
	output rst_req_e rst_req_o
);

	logic [SLV_IDX_BITS-1:0] slv;
	logic [ARCH_BITS-1:0] rd_word;

	// Two words per slave starting at offset 2
	assign slv = SLV_IDX_BITS'((ofs_i - 2'd2) >> 1);

	always_comb begin
		rd_word = '0;
		if (ofs_i == 0) begin
			rd_word = SOC_ID;
		end else if (ofs_i == 1) begin
			rd_word = ARCH_BITS'(SLAVE_COUNT);
		end else if (ofs_i < 2 + 2 * SLAVE_COUNT) begin
			if (!ofs_i[0]) begin
				// Id word, interrupt use flag on top
				rd_word = {DEVTBL_USEINTR[slv], DEVTBL_IDS[slv]};
			end else if (slv == SLV_IDX_BITS'(S_INVALIDDEV)) begin
				rd_word = INVALID_MAPSZ_BYTES;
			end else begin
				rd_word = SLOT_MAPSZ_BYTES;
			end
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			data_o <= '0;
		end else if (op_reads(op_i)) begin
			data_o <= rd_word;
		end
	end

	// Reset control bits live in byte 0 of the last word
	always_comb begin
		rst_req_o = RST_NONE;
		if (op_writes(op_i) && (ofs_i == DEVTBL_RST_OFS) && sel_i[0]) begin
			case (data_i[1:0])
				2'd3: rst_req_o = RST_COLD;
				2'd2: rst_req_o = RST_WARM;
				2'd1: rst_req_o = RST_PWROFF;
				default: rst_req_o = RST_NONE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- gpio_port.sv
`timescale 1ns/1ps
`default_nettype none

module gpio_port import soc_pkg::*; #(
	parameter int IO_COUNT = 16
) (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input pi1_op_e op_i,
	input logic [SLOT_OFS_BITS-1:0] ofs_i,
	input logic [ARCH_BITS-1:0] data_i,
	input logic [SEL_BITS-1:0] sel_i,
	output logic [ARCH_BITS-1:0] data_o,
	input logic [IO_COUNT-1:0] gp_i,
	output logic [IO_COUNT-1:0] gp_o,
	output logic int_rqst_o,
	input logic int_ack_i
);

	logic [IO_COUNT-1:0] sync_q1;
	logic [IO_COUNT-1:0] sync_q2;
	logic [IO_COUNT-1:0] prev_q;
	logic [IO_COUNT-1:0] out_q;
	logic [ARCH_BITS-1:0] in_word;
	logic [ARCH_BITS-1:0] out_word;
	logic [ARCH_BITS-1:0] new_word;

	// Two-flop synchroniser, then one more stage to spot changes
	always_ff @(posedge clk_2x_w) begin
		sync_q1 <= gp_i;
		sync_q2 <= sync_q1;
		prev_q <= sync_q2;
	end

	assign in_word = ARCH_BITS'(sync_q2);
	assign out_word = ARCH_BITS'(out_q);
	assign new_word = byte_merge(out_word, data_i, sel_i);

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			out_q <= '0;
			int_rqst_o <= 1'b0;
		end else begin
			// A fresh change wins over an ack in the same cycle
			if (sync_q2 != prev_q) begin
				int_rqst_o <= 1'b1;
			end else if (int_ack_i) begin
				int_rqst_o <= 1'b0;
			end
			if (op_writes(op_i) && (ofs_i == 1)) begin
				out_q <= new_word[IO_COUNT-1:0];
			end
		end
	end

	// Swap returns the value held before this write
	always_ff @(posedge clk_2x_w) begin
		if (op_reads(op_i)) begin
			case (ofs_i)
				4'd0: data_o <= in_word;
				4'd1: data_o <= out_word;
				default: data_o <= '0;
			endcase
		end
	end

	assign gp_o = out_q;

endmodule

`default_nettype wire

//--- int_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module int_ctrl import soc_pkg::*; (
	input logic clk_2x_w,
	input logic sys_rst_i,
	input pi1_op_e op_i,
	input logic [SLOT_OFS_BITS-1:0] ofs_i,
	input logic [ARCH_BITS-1:0] data_i,
	input logic [SEL_BITS-1:0] sel_i,
	output logic [ARCH_BITS-1:0] data_o,
	input logic [INT_SRC_COUNT-1:0] src_rqst_i,
	output logic [INT_SRC_COUNT-1:0] src_ack_o,
	output logic irq_o
);

	logic [INT_SRC_COUNT-1:0] mask_q;
	logic [INT_SRC_COUNT-1:0] pend;
	logic [INT_IDX_BITS-1:0] best;
	logic any;
	logic ack_rd;
	logic [ARCH_BITS-1:0] status;
	logic [ARCH_BITS-1:0] mask_word;
	logic [ARCH_BITS-1:0] new_mask;

	assign pend = src_rqst_i & mask_q;
	assign any = |pend;
	assign irq_o = any;

	// Lowest pending index wins
	always_comb begin
		best = '0;
		for (int i = INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (pend[i]) begin
				best = INT_IDX_BITS'(i);
			end
		end
	end

	assign status = {any, {(ARCH_BITS - 1 - INT_IDX_BITS){1'b0}}, best};
	assign mask_word = ARCH_BITS'(mask_q);
	assign new_mask = byte_merge(mask_word, data_i, sel_i);

	// Reading the status acknowledges the reported source
	assign ack_rd = op_reads(op_i) && (ofs_i == 0);
	assign src_ack_o = (ack_rd && any) ? (INT_SRC_COUNT'(1) << best) : '0;

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			mask_q <= '1;
		end else if (op_writes(op_i) && (ofs_i == 1)) begin
			mask_q <= new_mask[INT_SRC_COUNT-1:0];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (op_reads(op_i)) begin
			case (ofs_i)
				4'd0: data_o <= status;
				4'd1: data_o <= mask_word;
				default: data_o <= '0;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_top import soc_pkg::*; (
	input logic clk_2x_w,
	input logic rst_p,
	input pi1_op_e m_op_i,
	input logic [ADDR_BITS-1:0] m_addr_i,
	input logic [ARCH_BITS-1:0] m_data_i,
	input logic [SEL_BITS-1:0] m_sel_i,
	output logic [ARCH_BITS-1:0] m_data_o,
	output logic m_rdy_o,
	input logic [GP0_COUNT-1:0] gp0_i,
	output logic [GP0_COUNT-1:0] gp0_o,
	input logic [GP1_COUNT-1:0] gp1_i,
	output logic irq_o
);

	logic sys_rst;
	rst_req_e rst_req;
	pi1_op_e s_op [SLAVE_COUNT];
	logic [SLOT_OFS_BITS-1:0] s_ofs;
	logic [ARCH_BITS-1:0] s_wdata;
	logic [SEL_BITS-1:0] s_sel;
	logic [ARCH_BITS-1:0] s_rdata [SLAVE_COUNT];
	logic [INT_SRC_COUNT-1:0] int_rqst;
	logic [INT_SRC_COUNT-1:0] int_ack;

	// Invalid device slot has no module behind it
	assign s_rdata[S_INVALIDDEV] = '0;

	reset_sequencer reset_sequencer_i (
		.clk_2x_w(clk_2x_w),
		.rst_p(rst_p),
		.rst_req_i(rst_req),
		.sys_rst_o(sys_rst)
	);

	pi1_bus_decode pi1_bus_decode_i (
		.clk_2x_w(clk_2x_w),
		.sys_rst_i(sys_rst),
		.m_op_i(m_op_i),
		.m_addr_i(m_addr_i),
		.m_data_i(m_data_i),
		.m_sel_i(m_sel_i),
		.m_data_o(m_data_o),
		.m_rdy_o(m_rdy_o),
		.s_op_o(s_op),
		.s_ofs_o(s_ofs),
		.s_data_o(s_wdata),
		.s_sel_o(s_sel),
		.s_data_i(s_rdata)
	);

	dev_table dev_table_i (
		.clk_2x_w(clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i(s_op[S_DEVTBL]),
		.ofs_i(s_ofs),
		.data_i(s_wdata),
		.sel_i(s_sel),
		.data_o(s_rdata[S_DEVTBL]),
		.rst_req_o(rst_req)
	);

	gpio_port #(
		.IO_COUNT(GP0_COUNT)
	) gpio_switches_leds (
		.clk_2x_w(clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i(s_op[S_GP0IO]),
		.ofs_i(s_ofs),
		.data_i(s_wdata),
		.sel_i(s_sel),
		.data_o(s_rdata[S_GP0IO]),
		.gp_i(gp0_i),
		.gp_o(gp0_o),
		.int_rqst_o(int_rqst[INT_SRC_GP0]),
		.int_ack_i(int_ack[INT_SRC_GP0])
	);

	// Buttons are input only
	gpio_port #(
		.IO_COUNT(GP1_COUNT)
	) gpio_buttons (
		.clk_2x_w(clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i(s_op[S_GP1IO]),
		.ofs_i(s_ofs),
		.data_i(s_wdata),
		.sel_i(s_sel),
		.data_o(s_rdata[S_GP1IO]),
		.gp_i(gp1_i),
		.gp_o(),
		.int_rqst_o(int_rqst[INT_SRC_GP1]),
		.int_ack_i(int_ack[INT_SRC_GP1])
	);

	int_ctrl int_ctrl_i (
		.clk_2x_w(clk_2x_w),
		.sys_rst_i(sys_rst),
		.op_i(s_op[S_INTCTRL]),
		.ofs_i(s_ofs),
		.data_i(s_wdata),
		.sel_i(s_sel),
		.data_o(s_rdata[S_INTCTRL]),
		.src_rqst_i(int_rqst),
		.src_ack_o(int_ack),
		.irq_o(irq_o)
	);

endmodule

`default_nettype wire

//--- tb_soc_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_top import soc_pkg::*; ();

	localparam int CLK_PERIOD = 20;
	localparam int IRQ_WAIT = 8;
	localparam int RDY_WAIT = 4 * RST_CYCLES;
	localparam logic [ADDR_BITS-1:0] GP0_BASE = ADDR_BITS'(S_GP0IO * SLOT_WORDS);
	localparam logic [ADDR_BITS-1:0] INTC_BASE = ADDR_BITS'(S_INTCTRL * SLOT_WORDS);
	localparam logic [ADDR_BITS-1:0] INVALID_BASE = ADDR_BITS'(S_INVALIDDEV * SLOT_WORDS);
	// What a row checks after its operation
	localparam int CHK_NONE = 0;
	localparam int CHK_DATA = 1;
	localparam int CHK_IRQ_RISE = 2;
	localparam int CHK_DATA_IRQ_LOW = 3;
	localparam int CHK_IRQ_QUIET = 4;

	typedef struct packed {
		pi1_op_e op;
		logic [ADDR_BITS-1:0] addr;
		logic [ARCH_BITS-1:0] wdata;
		logic [SEL_BITS-1:0] sel;
		logic [GP0_COUNT-1:0] gp0;
		logic [GP1_COUNT-1:0] gp1;
		logic [ARCH_BITS-1:0] exp;
		int chk;
	} row_t;

	logic clk_2x_w;
	logic rst_p;
	pi1_op_e m_op_i;
	logic [ADDR_BITS-1:0] m_addr_i;
	logic [ARCH_BITS-1:0] m_data_i;
	logic [SEL_BITS-1:0] m_sel_i;
	logic [ARCH_BITS-1:0] m_data_o;
	logic m_rdy_o;
	logic [GP0_COUNT-1:0] gp0_i;
	logic [GP0_COUNT-1:0] gp0_o;
	logic [GP1_COUNT-1:0] gp1_i;
	logic irq_o;
	row_t rows[$];
	integer seed;
	int errors;
	logic [GP0_COUNT-1:0] cur_gp0;
	logic [GP1_COUNT-1:0] cur_gp1;
	logic [GP0_COUNT-1:0] led_model;

	soc_top dut_i (
		.clk_2x_w(clk_2x_w), .rst_p(rst_p),
		.m_op_i(m_op_i), .m_addr_i(m_addr_i), .m_data_i(m_data_i), .m_sel_i(m_sel_i),
		.m_data_o(m_data_o), .m_rdy_o(m_rdy_o),
		.gp0_i(gp0_i), .gp0_o(gp0_o), .gp1_i(gp1_i), .irq_o(irq_o)
	);

	initial begin
		clk_2x_w = 1'b0;
		forever #(CLK_PERIOD / 2) clk_2x_w = ~clk_2x_w;
	end

	task automatic add_row(input pi1_op_e op, input logic [ADDR_BITS-1:0] addr,
			input logic [ARCH_BITS-1:0] wdata, input logic [SEL_BITS-1:0] sel,
			input logic [ARCH_BITS-1:0] exp, input int chk);
		rows.push_back('{op, addr, wdata, sel, cur_gp0, cur_gp1, exp, chk});
	endtask

	task automatic build_table();
		logic [ARCH_BITS-1:0] rnd;
		logic [ARCH_BITS-1:0] word;
		add_row(OP_RD, 30'd0, '0, '1, SOC_ID, CHK_DATA);
		add_row(OP_RD, 30'd1, '0, '1, ARCH_BITS'(SLAVE_COUNT), CHK_DATA);
		for (int k = 0; k < SLAVE_COUNT; k++) begin
			word = ARCH_BITS'(DEVTBL_IDS[k]);
			word[ARCH_BITS-1] = DEVTBL_USEINTR[k];
			add_row(OP_RD, ADDR_BITS'(2 + 2 * k), '0, '1, word, CHK_DATA);
			word = (k == S_INVALIDDEV) ? INVALID_MAPSZ_BYTES : SLOT_MAPSZ_BYTES;
			add_row(OP_RD, ADDR_BITS'(3 + 2 * k), '0, '1, word, CHK_DATA);
		end
		add_row(OP_RD, ADDR_BITS'(DEVTBL_RST_OFS), '0, '1, '0, CHK_DATA);
		// LED register with partial byte selects and a swap
		rnd = $random(seed);
		led_model = rnd[15:0];
		add_row(OP_WR, GP0_BASE + 1, rnd, 4'b1111, '0, CHK_NONE);
		add_row(OP_RD, GP0_BASE + 1, '0, '1, ARCH_BITS'(led_model), CHK_DATA);
		rnd = $random(seed);
		led_model[15:8] = rnd[15:8];
		add_row(OP_WR, GP0_BASE + 1, rnd, 4'b0010, '0, CHK_NONE);
		add_row(OP_RD, GP0_BASE + 1, '0, '1, ARCH_BITS'(led_model), CHK_DATA);
		rnd = $random(seed);
		led_model[7:0] = rnd[7:0];
		add_row(OP_WR, GP0_BASE + 1, rnd, 4'b0101, '0, CHK_NONE);
		add_row(OP_RD, GP0_BASE + 1, '0, '1, ARCH_BITS'(led_model), CHK_DATA);
		rnd = $random(seed) | 1;
		add_row(OP_RDWR, GP0_BASE + 1, rnd, 4'b1111, ARCH_BITS'(led_model), CHK_DATA);
		led_model = rnd[15:0];
		add_row(OP_RD, GP0_BASE + 1, '0, '1, ARCH_BITS'(led_model), CHK_DATA);
		// Switch inputs also raise the source 0 interrupt
		cur_gp0 = GP0_COUNT'($random(seed)) | 1;
		add_row(OP_NOP, '0, '0, '0, '0, CHK_NONE);
		add_row(OP_NOP, '0, '0, '0, '0, CHK_NONE);
		add_row(OP_RD, GP0_BASE, '0, '1, ARCH_BITS'(cur_gp0), CHK_DATA);
		// Unmapped space including offsets that match real registers
		add_row(OP_RD, INVALID_BASE, '0, '1, '0, CHK_DATA);
		add_row(OP_RD, 30'h3fff_fff5, '0, '1, '0, CHK_DATA);
		add_row(OP_WR, INVALID_BASE + 1, '0, '1, '0, CHK_NONE);
		add_row(OP_WR, INVALID_BASE + DEVTBL_RST_OFS, 32'h2, 4'b0001, '0, CHK_NONE);
		add_row(OP_RDWR, INVALID_BASE + SLOT_WORDS + 1, '1, '1, '0, CHK_DATA);
		add_row(OP_RD, GP0_BASE + 1, '0, '1, ARCH_BITS'(led_model), CHK_DATA);
		add_row(OP_RD, INTC_BASE + 1, '0, '1, 32'h3, CHK_DATA);
		add_row(OP_RD, 30'd0, '0, '1, SOC_ID, CHK_DATA);
		// Interrupt status, acknowledge and mask
		add_row(OP_RD, INTC_BASE, '0, '1, 32'h8000_0000 | INT_SRC_GP0, CHK_DATA_IRQ_LOW);
		cur_gp1 = GP1_COUNT'($random(seed)) | 1;
		add_row(OP_NOP, '0, '0, '0, '0, CHK_IRQ_RISE);
		add_row(OP_RD, INTC_BASE, '0, '1, 32'h8000_0000 | INT_SRC_GP1, CHK_DATA_IRQ_LOW);
		add_row(OP_WR, INTC_BASE + 1, 32'h1, 4'b0001, '0, CHK_NONE);
		add_row(OP_RD, INTC_BASE + 1, '0, '1, 32'h1, CHK_DATA);
		cur_gp1 = ~cur_gp1;
		add_row(OP_NOP, '0, '0, '0, '0, CHK_IRQ_QUIET);
		add_row(OP_RD, INTC_BASE, '0, '1, '0, CHK_DATA);
	endtask

	task automatic check_value(input string name, input string where,
			input logic [ARCH_BITS-1:0] exp, input logic [ARCH_BITS-1:0] act);
		assert (act === exp) else begin
			errors++;
			$display("Fail %s at %s: expected %h, actual %h", name, where, exp, act);
		end
	endtask

	// Drive one request, hold it while not ready, sample the cycle after acceptance
	task automatic bus_op(input pi1_op_e op, input logic [ADDR_BITS-1:0] addr,
			input logic [ARCH_BITS-1:0] wdata, input logic [SEL_BITS-1:0] sel,
			input logic [GP0_COUNT-1:0] gp0, input logic [GP1_COUNT-1:0] gp1,
			output logic [ARCH_BITS-1:0] rdata);
		int waits;
		@(posedge clk_2x_w);
		m_op_i <= op;
		m_addr_i <= addr;
		m_data_i <= wdata;
		m_sel_i <= sel;
		gp0_i <= gp0;
		gp1_i <= gp1;
		@(negedge clk_2x_w);
		waits = 0;
		while (m_rdy_o !== 1'b1 && waits < RDY_WAIT) begin
			@(negedge clk_2x_w);
			waits++;
		end
		assert (m_rdy_o === 1'b1) else begin
			errors++;
			$display("Bus stayed not ready for %0d cycles at address %h", waits, addr);
		end
		@(posedge clk_2x_w);
		m_op_i <= OP_NOP;
		@(negedge clk_2x_w);
		rdata = m_data_o;
	endtask

	task automatic run_row(input int idx);
		row_t r;
		logic [ARCH_BITS-1:0] rdata;
		string where;
		int n;
		logic seen;
		r = rows[idx];
		where = $sformatf("row %0d", idx);
		bus_op(r.op, r.addr, r.wdata, r.sel, r.gp0, r.gp1, rdata);
		if (r.chk == CHK_DATA || r.chk == CHK_DATA_IRQ_LOW) begin
			check_value("m_data_o", where, r.exp, rdata);
		end
		if (r.chk == CHK_DATA_IRQ_LOW) begin
			check_value("irq_o", where, '0, ARCH_BITS'(irq_o));
		end
		// LEDs follow the output register
		if (r.op == OP_RD && r.addr == GP0_BASE + 1) begin
			check_value("gp0_o", where, r.exp, ARCH_BITS'(gp0_o));
		end
		if (r.chk == CHK_IRQ_RISE) begin
			n = 0;
			while (irq_o !== 1'b1 && n < IRQ_WAIT) begin
				@(negedge clk_2x_w);
				n++;
			end
			assert (irq_o === 1'b1) else begin
				errors++;
				$display("irq_o did not rise within %0d cycles in %s", IRQ_WAIT, where);
			end
		end
		if (r.chk == CHK_IRQ_QUIET) begin
			seen = 1'b0;
			repeat (IRQ_WAIT) begin
				@(negedge clk_2x_w);
				seen = seen | (irq_o !== 1'b0);
			end
			assert (!seen) else begin
				errors++;
				$display("irq_o rose for a masked source in %s", where);
			end
		end
	endtask

	task automatic release_reset();
		repeat (3) @(posedge clk_2x_w);
		rst_p <= 1'b0;
		@(negedge clk_2x_w);
	endtask

	// Counts cycles until ready while the bus outputs stay quiet
	task automatic wait_ready(input string what);
		int cycles;
		cycles = 0;
		while (m_rdy_o !== 1'b1 && cycles < RDY_WAIT) begin
			check_value("m_data_o", what, '0, m_data_o);
			check_value("irq_o", what, '0, ARCH_BITS'(irq_o));
			@(negedge clk_2x_w);
			cycles++;
		end
		assert (cycles == RST_CYCLES) else begin
			errors++;
			$display("Reset after %s lasted %0d cycles instead of %0d", what, cycles, RST_CYCLES);
		end
	endtask

	task automatic soft_reset_check();
		logic [ARCH_BITS-1:0] rdata;
		logic seen;
		check_value("gp0_o", "warm reset", ARCH_BITS'(led_model), ARCH_BITS'(gp0_o));
		bus_op(OP_WR, ADDR_BITS'(DEVTBL_RST_OFS), 32'h2, 4'b0001, cur_gp0, cur_gp1, rdata);
		check_value("m_rdy_o", "warm reset", '0, ARCH_BITS'(m_rdy_o));
		wait_ready("warm reset");
		check_value("gp0_o", "warm reset", '0, ARCH_BITS'(gp0_o));
		bus_op(OP_WR, ADDR_BITS'(DEVTBL_RST_OFS), 32'h1, 4'b0001, cur_gp0, cur_gp1, rdata);
		seen = 1'b0;
		repeat (3 * RST_CYCLES) begin
			@(negedge clk_2x_w);
			seen = seen | (m_rdy_o !== 1'b0);
		end
		assert (!seen) else begin
			errors++;
			$display("m_rdy_o came back after power-off without rst_p");
		end
		@(posedge clk_2x_w);
		rst_p <= 1'b1;
		release_reset();
		wait_ready("power-off");
		bus_op(OP_RD, 30'd0, '0, '1, cur_gp0, cur_gp1, rdata);
		check_value("m_data_o", "power-off", SOC_ID, rdata);
	endtask

	initial begin : watchdog
		int unsigned limit;
		#1;
		limit = rows.size() * 40 + 8 * RST_CYCLES + 64;
		#(limit * CLK_PERIOD);
		$display("Run timed out after %0d cycles", limit);
		$display("Test failed");
		$finish;
	end

	initial begin
		seed = 32'h6d33_6451;
		errors = 0;
		rst_p = 1'b1;
		m_op_i = OP_NOP;
		m_addr_i = '0;
		m_data_i = '0;
		m_sel_i = '0;
		gp0_i = '0;
		gp1_i = '0;
		cur_gp0 = '0;
		cur_gp1 = '0;
		build_table();
		release_reset();
		wait_ready("power-on");
		for (int i = 0; i < rows.size(); i++) begin
			run_row(i);
		end
		soft_reset_check();
		$display("Checks finished with %0d errors", errors);
		if (errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
soc_pkg.sv
reset_sequencer.sv
pi1_bus_decode.sv
dev_table.sv
gpio_port.sv
int_ctrl.sv
soc_top.sv
tb_soc_top.sv

//--- Bender.yml
package:
  name: soc_perint

sources:
  - soc_pkg.sv
  - reset_sequencer.sv
  - pi1_bus_decode.sv
  - dev_table.sv
  - gpio_port.sv
  - int_ctrl.sv
  - soc_top.sv
  - target: test
    files:
      - tb_soc_top.sv
